//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rename_top -f sim.f \
    && ./obj_dir/Vtb_rename_top | grep "STATUS: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim.f
verilog/rename_pkg.sv
verilog/inst_queue.sv
verilog/decoder.sv
verilog/id_stage.sv
verilog/rat.sv
verilog/free_list.sv
verilog/rob_alloc.sv
verilog/rename_top.sv
test/tb_rename_top.sv

//--- test/tb_rename_top.sv
`timescale 1ns/1ns

module tb_rename_top
import rename_pkg::*;
();
    localparam int CYCLES      = 2000;
    localparam int DRAIN_LIMIT = 500;

    logic           clk;
    logic           rst;
    logic           fetch_valid;
    fetch_packet_t  fetch_packet;
    logic           fetch_ready;
    logic           dispatch_valid;
    logic           dispatch_ready;
    uop_t           dispatch_uops [ID_WIDTH];
    logic           retire;

    // Reference model state
    integer         seed;
    fetch_packet_t  pkt_q [$];
    int             free_q [$];
    int             rob_q [$];
    int             rat_map [32];
    int             rob_next;
    logic           second_beat;

    rename_top #(.QUEUE_DEPTH(4)) rename_top_inst (
        .clk, .rst, .fetch_valid, .fetch_packet, .fetch_ready,
        .dispatch_valid, .dispatch_ready, .dispatch_uops, .retire
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r[30:0] % 100) < pct;
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic logic [31:0] rand_inst();
        logic [6:0]  opcodes [9];
        logic [31:0] w;
        logic [31:0] r;
        opcodes = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h33, 7'h13, 7'h37, 7'h17};
        w = $random(seed);
        r = $random(seed);
        w[6:0] = opcodes[r[30:0] % 9];
        // Registers kept to x0..x7 so lanes collide often
        w[11:7]  = {2'b00, w[9:7]};
        w[19:15] = {2'b00, w[17:15]};
        w[24:20] = {2'b00, w[22:20]};
        return w;
    endfunction

    function automatic fetch_packet_t rand_packet();
        fetch_packet_t p;
        logic [31:0]   r;
        p.pc      = $random(seed);
        p.pc[1:0] = 2'b00;
        p.inst[0] = rand_inst();
        p.inst[1] = rand_inst();
        r = $random(seed);
        p.valid = r[1:0];
        return p;
    endfunction

    ////////////////////
    // Model
    ////////////////////

    // Class and format letter from the opcode
    task automatic decode(input logic [31:0] w, output rs_type_t cls, output logic [31:0] imm,
                          output logic [4:0] rd, output logic [4:0] rs1, output logic [4:0] rs2);
        byte fmt;
        case (w[6:0])
            7'h03, 7'h23: cls = RS_MEM;
            7'h63, 7'h6f, 7'h67: cls = RS_BR;
            default: cls = RS_ALU;
        endcase
        case (w[6:0])
            7'h23: fmt = "S";
            7'h63: fmt = "B";
            7'h6f: fmt = "J";
            7'h33: fmt = "R";
            7'h37, 7'h17: fmt = "U";
            default: fmt = "I";
        endcase
        rd  = (fmt == "S" || fmt == "B") ? 5'd0 : w[11:7];
        rs1 = (fmt == "U" || fmt == "J") ? 5'd0 : w[19:15];
        rs2 = (fmt == "R" || fmt == "S" || fmt == "B") ? w[24:20] : 5'd0;
        case (fmt)
            "I": imm = {{20{w[31]}}, w[31:20]};
            "S": imm = {{20{w[31]}}, w[31:25], w[11:7]};
            "B": imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            "J": imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            "U": imm = {w[31:12], 12'h000};
            default: imm = '0;
        endcase
    endtask

    // One firing beat against the head of the model queue
    task automatic check_beat();
        fetch_packet_t p;
        logic          split;
        logic [1:0]    mask;
        rs_type_t      cls [2];
        logic [31:0]   imm [2];
        logic [4:0]    rd [2];
        logic [4:0]    rs1 [2];
        logic [4:0]    rs2 [2];
        int            rd_phy;
        string         tag;
        p = pkt_q[0];
        for (int i = 0; i < 2; i++) begin
            decode(p.inst[i], cls[i], imm[i], rd[i], rs1[i], rs2[i]);
        end
        split = p.valid[0] && (cls[0] == RS_BR
                || (cls[0] == RS_MEM && p.valid[1] && cls[1] == RS_MEM));
        mask = !split ? 2'b11 : (second_beat ? 2'b10 : 2'b01);

        // Lanes go in program order so lane 1 sees lane 0's new mapping
        for (int i = 0; i < 2; i++) begin
            tag = $sformatf("uop%0d", i);
            check({tag, ".valid"}, p.valid[i] && mask[i], dispatch_uops[i].valid);
            if (p.valid[i] && mask[i]) begin
                check({tag, ".pc"}, p.pc + 4 * i, dispatch_uops[i].pc);
                check({tag, ".inst"}, p.inst[i], dispatch_uops[i].inst);
                check({tag, ".rs_type"}, cls[i], dispatch_uops[i].rs_type);
                check({tag, ".imm"}, imm[i], dispatch_uops[i].imm);
                check({tag, ".rd_arch"}, rd[i], dispatch_uops[i].rd_arch);
                check({tag, ".rs1_arch"}, rs1[i], dispatch_uops[i].rs1_arch);
                check({tag, ".rs2_arch"}, rs2[i], dispatch_uops[i].rs2_arch);
                check({tag, ".rs1_phy"}, rat_map[rs1[i]], dispatch_uops[i].rs1_phy);
                check({tag, ".rs2_phy"}, rat_map[rs2[i]], dispatch_uops[i].rs2_phy);
                rd_phy = 0;
                if (rd[i] != 5'd0) begin
                    rd_phy = free_q.pop_front();
                    rob_q.push_back(rat_map[rd[i]]);
                    rat_map[rd[i]] = rd_phy;
                end else begin
                    rob_q.push_back(-1);
                end
                check({tag, ".rd_phy"}, rd_phy, dispatch_uops[i].rd_phy);
                check({tag, ".rob_id"}, rob_next, dispatch_uops[i].rob_id);
                rob_next = (rob_next + 1) % ROB_DEPTH;
            end
        end

        if (split && !second_beat) begin
            second_beat = 1'b1;
        end else begin
            second_beat = 1'b0;
            void'(pkt_q.pop_front());
        end
    endtask

    // Check the edge, update the model, then drive the next inputs
    task automatic step(input logic active);
        int old;
        check("dispatch_valid", pkt_q.size() > 0 && free_q.size() >= 2
              && rob_q.size() <= ROB_DEPTH - 2, dispatch_valid);
        check("fetch_ready", pkt_q.size() < 4, fetch_ready);
        if (dispatch_valid && dispatch_ready) begin
            check_beat();
        end
        if (retire) begin
            old = rob_q.pop_front();
            if (old >= 0) begin
                free_q.push_back(old);
            end
        end
        if (fetch_valid && fetch_ready) begin
            pkt_q.push_back(fetch_packet);
        end
        fetch_valid    <= active && chance(70);
        fetch_packet   <= rand_packet();
        dispatch_ready <= !active || chance(75);
        retire         <= rob_q.size() > 0 && (!active || chance(35));
    endtask

    initial begin
        int wait_cnt;
        seed           = 81133;
        rst            = 1'b1;
        fetch_valid    = 1'b0;
        fetch_packet   = '0;
        dispatch_ready = 1'b0;
        retire         = 1'b0;
        second_beat    = 1'b0;
        rob_next       = 0;
        for (int r = 0; r < 32; r++) begin
            rat_map[r] = r;
        end
        for (int n = 32; n < PHYS_REGS; n++) begin
            free_q.push_back(n);
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int cycle = 0; cycle < CYCLES; cycle++) begin
            @(posedge clk);
            step(1'b1);
        end

        // Drain with fetch off, dispatch open and retire on every cycle
        wait_cnt = 0;
        while ((pkt_q.size() > 0 || rob_q.size() > 0) && wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            step(1'b0);
            wait_cnt++;
        end

        if (pkt_q.size() > 0 || rob_q.size() > 0) begin
            $display("Drain did not finish within %0d cycles", DRAIN_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ns

module decoder
import rename_pkg::*;
(
    input  logic [31:0]     inst,
    output dec_t            dec
);
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Fields a format does not use stay zero
    always_comb begin
        dec = '0;
        dec.rs_type = RS_ALU;
        case (inst[6:0])
            OPC_LOAD: begin
                dec.rs_type  = RS_MEM;
                dec.imm      = imm_i;
                dec.rd_arch  = inst[11:7];
                dec.rs1_arch = inst[19:15];
            end
            OPC_STORE: begin
                dec.rs_type  = RS_MEM;
                dec.imm      = imm_s;
                dec.rs1_arch = inst[19:15];
                dec.rs2_arch = inst[24:20];
            end
            OPC_BRANCH: begin
                dec.rs_type  = RS_BR;
                dec.imm      = imm_b;
                dec.rs1_arch = inst[19:15];
                dec.rs2_arch = inst[24:20];
            end
            OPC_JAL: begin
                dec.rs_type  = RS_BR;
                dec.imm      = imm_j;
                dec.rd_arch  = inst[11:7];
            end
            OPC_JALR: begin
                dec.rs_type  = RS_BR;
                dec.imm      = imm_i;
                dec.rd_arch  = inst[11:7];
                dec.rs1_arch = inst[19:15];
            end
            OPC_OP: begin
                dec.rd_arch  = inst[11:7];
                dec.rs1_arch = inst[19:15];
                dec.rs2_arch = inst[24:20];
            end
            OPC_OPIMM: begin
                dec.imm      = imm_i;
                dec.rd_arch  = inst[11:7];
                dec.rs1_arch = inst[19:15];
            end
            OPC_LUI, OPC_AUIPC: begin
                dec.imm      = imm_u;
                dec.rd_arch  = inst[11:7];
            end
            default: begin
                dec.rs_type  = RS_ALU;
            end
        endcase
    end

endmodule

//--- verilog/free_list.sv
`timescale 1ns/1ns

module free_list
import rename_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                fl_pop [ID_WIDTH],
    input  logic                free_push,
    input  logic [PRF_IDX-1:0]  free_push_idx,
    output logic                fl_ready,
    output logic [PRF_IDX-1:0]  fl_idx [ID_WIDTH]
);
    localparam int CNT_W     = $clog2(PHYS_REGS + 1);
    localparam int INIT_FREE = PHYS_REGS / 2;

    logic [PRF_IDX-1:0] mem [PHYS_REGS];
    logic [PRF_IDX-1:0] rd_ptr;
    logic [PRF_IDX-1:0] wr_ptr;
    logic [CNT_W-1:0]   count;
    logic [1:0]         npop;

    assign npop      = {1'b0, fl_pop[0]} + {1'b0, fl_pop[1]};
    assign fl_ready  = (count >= CNT_W'(2));
    assign fl_idx[0] = mem[rd_ptr];
    assign fl_idx[1] = mem[rd_ptr + 1'b1];

    // Upper half of the physical file starts out free
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < INIT_FREE; i++) begin
                mem[i] <= PRF_IDX'(INIT_FREE + i);
            end
            rd_ptr <= '0;
            wr_ptr <= PRF_IDX'(INIT_FREE);
            count  <= CNT_W'(INIT_FREE);
        end else begin
            if (free_push) begin
                mem[wr_ptr] <= free_push_idx;
                wr_ptr      <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + PRF_IDX'(npop);
            count  <= count + CNT_W'(free_push) - CNT_W'(npop);
        end
    end

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/1ns

module id_stage
import rename_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                head_valid,
    input  fetch_packet_t       head_packet,
    output logic                head_pop,
    output rat_req_t            rat_req,
    input  logic [PRF_IDX-1:0]  rat_rs1_phy [ID_WIDTH],
    input  logic [PRF_IDX-1:0]  rat_rs2_phy [ID_WIDTH],
    input  logic [PRF_IDX-1:0]  rat_rd_old [ID_WIDTH],
    input  logic                fl_ready,
    input  logic [PRF_IDX-1:0]  fl_idx [ID_WIDTH],
    output logic                fl_pop [ID_WIDTH],
    input  logic                rob_ready,
    input  logic [ROB_IDX-1:0]  rob_id [ID_WIDTH],
    output rob_alloc_t          rob_alloc,
    output logic                dispatch_valid,
    input  logic                dispatch_ready,
    output uop_t                dispatch_uops [ID_WIDTH]
);
    dec_t                   dec [ID_WIDTH];
    logic [ID_WIDTH-1:0]    raw_valid;
    logic [ID_WIDTH-1:0]    lane_mask;
    logic [ID_WIDTH-1:0]    lane_valid;
    logic [ID_WIDTH-1:0]    need_rd;
    logic                   split;
    logic                   second_beat;
    logic                   fire;
    logic [PRF_IDX-1:0]     rd_phy [ID_WIDTH];
    logic [PRF_IDX-1:0]     rs1_phy [ID_WIDTH];
    logic [PRF_IDX-1:0]     rs2_phy [ID_WIDTH];
    logic [PRF_IDX-1:0]     rd_old [ID_WIDTH];
    logic [ROB_IDX-1:0]     slot [ID_WIDTH];
    logic                   same_rd;

    for (genvar i = 0; i < ID_WIDTH; i++) begin : g_dec
        decoder decoder_inst (
            .inst   (head_packet.inst[i]),
            .dec    (dec[i])
        );
        assign raw_valid[i] = head_valid && head_packet.valid[i];
    end

    ////////////////////
    // Dispatch filter
    ////////////////////

    assign split = (raw_valid[0] && dec[0].rs_type == RS_BR)
                || (raw_valid[0] && dec[0].rs_type == RS_MEM
                    && raw_valid[1] && dec[1].rs_type == RS_MEM);
    assign lane_mask      = !split ? 2'b11 : (second_beat ? 2'b10 : 2'b01);
    assign lane_valid     = raw_valid & lane_mask;
    assign dispatch_valid = head_valid && fl_ready && rob_ready;
    assign fire           = dispatch_valid && dispatch_ready;
    assign head_pop       = fire && (!split || second_beat);

    always_ff @(posedge clk) begin
        if (rst) begin
            second_beat <= 1'b0;
        end else if (fire && split) begin
            second_beat <= !second_beat;
        end
    end

    ////////////////////
    // Rename
    ////////////////////

    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            need_rd[i] = lane_valid[i] && (dec[i].rd_arch != '0);
            fl_pop[i]  = fire && need_rd[i];
        end
        // A lone lane 1 takes the oldest free number and the first slot
        rd_phy[0] = need_rd[0] ? fl_idx[0] : '0;
        rd_phy[1] = !need_rd[1] ? '0 : (need_rd[0] ? fl_idx[1] : fl_idx[0]);
        slot[0]   = rob_id[0];
        slot[1]   = lane_valid[0] ? rob_id[1] : rob_id[0];

        // Lane 1 sees lane 0's new mapping
        same_rd    = need_rd[0] && (dec[1].rd_arch == dec[0].rd_arch);
        rs1_phy[0] = rat_rs1_phy[0];
        rs2_phy[0] = rat_rs2_phy[0];
        rd_old[0]  = rat_rd_old[0];
        rs1_phy[1] = (need_rd[0] && dec[1].rs1_arch == dec[0].rd_arch) ? rd_phy[0]
                                                                         : rat_rs1_phy[1];
        rs2_phy[1] = (need_rd[0] && dec[1].rs2_arch == dec[0].rd_arch) ? rd_phy[0]
                                                                         : rat_rs2_phy[1];
        rd_old[1]  = same_rd ? rd_phy[0] : rat_rd_old[1];
    end

    always_comb begin
        rob_alloc.valid = fire;
        for (int i = 0; i < ID_WIDTH; i++) begin
            rat_req.rs1_arch[i] = dec[i].rs1_arch;
            rat_req.rs2_arch[i] = dec[i].rs2_arch;
            rat_req.old_arch[i] = dec[i].rd_arch;
            rat_req.wr_arch[i]  = dec[i].rd_arch;
            rat_req.wr_phy[i]   = rd_phy[i];

            rob_alloc.inst_valid[i] = lane_valid[i];
            rob_alloc.rd_arch[i]    = dec[i].rd_arch;
            rob_alloc.rd_phy[i]     = rd_phy[i];
            rob_alloc.rd_old[i]     = rd_old[i];

            dispatch_uops[i].valid    = lane_valid[i];
            dispatch_uops[i].pc       = head_packet.pc + 32'(4 * i);
            dispatch_uops[i].inst     = head_packet.inst[i];
            dispatch_uops[i].rs_type  = dec[i].rs_type;
            dispatch_uops[i].imm      = dec[i].imm;
            dispatch_uops[i].rd_arch  = dec[i].rd_arch;
            dispatch_uops[i].rs1_arch = dec[i].rs1_arch;
            dispatch_uops[i].rs2_arch = dec[i].rs2_arch;
            dispatch_uops[i].rd_phy   = rd_phy[i];
            dispatch_uops[i].rs1_phy  = rs1_phy[i];
            dispatch_uops[i].rs2_phy  = rs2_phy[i];
            dispatch_uops[i].rob_id   = slot[i];
        end
        // Lane 1 wins when both lanes write the same register
        rat_req.we[0] = fire && need_rd[0] && !(need_rd[1] && same_rd);
        rat_req.we[1] = fire && need_rd[1];
    end

endmodule

//--- verilog/inst_queue.sv
`timescale 1ns/1ns

module inst_queue
import rename_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_valid,
    input  fetch_packet_t   fetch_packet,
    output logic            fetch_ready,
    output logic            head_valid,
    output fetch_packet_t   head_packet,
    input  logic            head_pop
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_packet_t      mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;

    assign fetch_ready = (count != CNT_W'(QUEUE_DEPTH));
    assign head_valid  = (count != '0);
    assign head_packet = mem[rd_ptr];
    assign push        = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch_packet;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (head_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(head_pop);
        end
    end

endmodule

//--- verilog/rat.sv
`timescale 1ns/1ns

module rat
import rename_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  rat_req_t            rat_req,
    output logic [PRF_IDX-1:0]  rs1_phy [ID_WIDTH],
    output logic [PRF_IDX-1:0]  rs2_phy [ID_WIDTH],
    output logic [PRF_IDX-1:0]  rd_old [ID_WIDTH]
);
    localparam int ARF_REGS = 1 << ARF_IDX;

    logic [PRF_IDX-1:0] map [ARF_REGS];

    // x0 is hardwired to physical 0
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            rs1_phy[i] = (rat_req.rs1_arch[i] == '0) ? '0 : map[rat_req.rs1_arch[i]];
            rs2_phy[i] = (rat_req.rs2_arch[i] == '0) ? '0 : map[rat_req.rs2_arch[i]];
            rd_old[i]  = (rat_req.old_arch[i] == '0) ? '0 : map[rat_req.old_arch[i]];
        end
    end

    // Identity map after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARF_REGS; r++) begin
                map[r] <= PRF_IDX'(r);
            end
        end else begin
            // Later lane overrides an earlier one
            for (int i = 0; i < ID_WIDTH; i++) begin
                if (rat_req.we[i] && rat_req.wr_arch[i] != '0) begin
                    map[rat_req.wr_arch[i]] <= rat_req.wr_phy[i];
                end
            end
        end
    end

endmodule

//--- verilog/rename_pkg.sv
package rename_pkg;

    // Machine widths
    localparam int ID_WIDTH  = 2;
    localparam int ARF_IDX   = 5;
    localparam int PHYS_REGS = 64;
    localparam int PRF_IDX   = 6;
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX   = 4;

    typedef enum logic [1:0] {
        RS_ALU = 2'd0,
        RS_BR  = 2'd1,
        RS_MEM = 2'd2
    } rs_type_t;

    // Two instruction words behind one PC
    typedef struct packed {
        logic [31:0]                pc;
        logic [ID_WIDTH-1:0][31:0]  inst;
        logic [ID_WIDTH-1:0]        valid;
    } fetch_packet_t;

    typedef struct packed {
        rs_type_t                   rs_type;
        logic [31:0]                imm;
        logic [ARF_IDX-1:0]         rd_arch;
        logic [ARF_IDX-1:0]         rs1_arch;
        logic [ARF_IDX-1:0]         rs2_arch;
    } dec_t;

    typedef struct packed {
        logic                       valid;
        logic [31:0]                pc;
        logic [31:0]                inst;
        rs_type_t                   rs_type;
        logic [31:0]                imm;
        logic [ARF_IDX-1:0]         rd_arch;
        logic [ARF_IDX-1:0]         rs1_arch;
        logic [ARF_IDX-1:0]         rs2_arch;
        logic [PRF_IDX-1:0]         rd_phy;
        logic [PRF_IDX-1:0]         rs1_phy;
        logic [PRF_IDX-1:0]         rs2_phy;
        logic [ROB_IDX-1:0]         rob_id;
    } uop_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0][ARF_IDX-1:0]   rs1_arch;
        logic [ID_WIDTH-1:0][ARF_IDX-1:0]   rs2_arch;
        logic [ID_WIDTH-1:0][ARF_IDX-1:0]   old_arch;
        logic [ID_WIDTH-1:0]                we;
        logic [ID_WIDTH-1:0][ARF_IDX-1:0]   wr_arch;
        logic [ID_WIDTH-1:0][PRF_IDX-1:0]   wr_phy;
    } rat_req_t;

    typedef struct packed {
        logic                               valid;
        logic [ID_WIDTH-1:0]                inst_valid;
        logic [ID_WIDTH-1:0][ARF_IDX-1:0]   rd_arch;
        logic [ID_WIDTH-1:0][PRF_IDX-1:0]   rd_phy;
        logic [ID_WIDTH-1:0][PRF_IDX-1:0]   rd_old;
    } rob_alloc_t;

endpackage

//--- verilog/rename_top.sv
`timescale 1ns/1ns

module rename_top
import rename_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_valid,
    input  fetch_packet_t   fetch_packet,
    output logic            fetch_ready,
    output logic            dispatch_valid,
    input  logic            dispatch_ready,
    output uop_t            dispatch_uops [ID_WIDTH],
    input  logic            retire
);
    logic               head_valid;
    fetch_packet_t      head_packet;
    logic               head_pop;
    rat_req_t           rat_req;
    logic [PRF_IDX-1:0] rat_rs1_phy [ID_WIDTH];
    logic [PRF_IDX-1:0] rat_rs2_phy [ID_WIDTH];
    logic [PRF_IDX-1:0] rat_rd_old [ID_WIDTH];
    logic               fl_ready;
    logic [PRF_IDX-1:0] fl_idx [ID_WIDTH];
    logic               fl_pop [ID_WIDTH];
    logic               rob_ready;
    logic [ROB_IDX-1:0] rob_id [ID_WIDTH];
    rob_alloc_t         rob_req;
    logic               free_push;
    logic [PRF_IDX-1:0] free_push_idx;

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_inst (
        .clk, .rst, .fetch_valid, .fetch_packet, .fetch_ready,
        .head_valid, .head_packet, .head_pop
    );

    id_stage id_stage_inst (
        .clk, .rst, .head_valid, .head_packet, .head_pop, .rat_req,
        .rat_rs1_phy, .rat_rs2_phy, .rat_rd_old, .fl_ready, .fl_idx, .fl_pop,
        .rob_ready, .rob_id, .rob_alloc(rob_req),
        .dispatch_valid, .dispatch_ready, .dispatch_uops
    );

    rat rat_inst (
        .clk, .rst, .rat_req,
        .rs1_phy(rat_rs1_phy), .rs2_phy(rat_rs2_phy), .rd_old(rat_rd_old)
    );

    free_list free_list_inst (
        .clk, .rst, .fl_pop, .free_push, .free_push_idx, .fl_ready, .fl_idx
    );

    rob_alloc rob_alloc_inst (
        .clk, .rst, .rob_alloc(rob_req), .retire,
        .rob_ready, .rob_id, .free_push, .free_push_idx
    );

endmodule

//--- verilog/rob_alloc.sv
`timescale 1ns/1ns

module rob_alloc
import rename_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  rob_alloc_t          rob_alloc,
    input  logic                retire,
    output logic                rob_ready,
    output logic [ROB_IDX-1:0]  rob_id [ID_WIDTH],
    output logic                free_push,
    output logic [PRF_IDX-1:0]  free_push_idx
);
    logic               has_dest [ROB_DEPTH];
    logic [PRF_IDX-1:0] old_phy [ROB_DEPTH];
    logic [ROB_IDX-1:0] head;
    logic [ROB_IDX-1:0] tail;
    logic [ROB_IDX:0]   count;
    logic [ROB_IDX-1:0] slot1;
    logic [1:0]         nalloc;

    assign rob_ready = (count <= (ROB_IDX + 1)'(ROB_DEPTH - 2));
    assign rob_id[0] = tail;
    assign rob_id[1] = tail + 1'b1;
    assign slot1     = tail + ROB_IDX'(rob_alloc.inst_valid[0]);
    assign nalloc    = rob_alloc.valid ? ({1'b0, rob_alloc.inst_valid[0]}
                                        + {1'b0, rob_alloc.inst_valid[1]}) : 2'd0;

    // Old mapping goes back to the free list as the entry retires
    assign free_push     = retire && has_dest[head];
    assign free_push_idx = old_phy[head];

    always_ff @(posedge clk) begin
        if (rob_alloc.valid && rob_alloc.inst_valid[0]) begin
            has_dest[tail] <= (rob_alloc.rd_arch[0] != '0) && (rob_alloc.rd_phy[0] != '0);
            old_phy[tail]  <= rob_alloc.rd_old[0];
        end
        if (rob_alloc.valid && rob_alloc.inst_valid[1]) begin
            has_dest[slot1] <= (rob_alloc.rd_arch[1] != '0) && (rob_alloc.rd_phy[1] != '0);
            old_phy[slot1]  <= rob_alloc.rd_old[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + ROB_IDX'(nalloc);
            head  <= head + ROB_IDX'(retire);
            count <= count + (ROB_IDX + 1)'(nalloc) - (ROB_IDX + 1)'(retire);
        end
    end

endmodule
